//--- verilog/spi_pkg.sv
// Shared frame layout, command codes and transfer types for the SPI register master
package spi_pkg;

  // fixed frame geometry
  localparam int FRAME_BITS  = 40;
  localparam int CS_LINES    = 4;
  localparam int CS_SEL_BITS = 2;

  // byte a peripheral shifts back in the command slot
  localparam logic [7:0] STATUS_BYTE = 8'h5A;

  // read flag position inside the command byte
  localparam int CMD_READ_BIT = 7;

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } spi_op_e;

  // on-wire order is cmd, addr, data, msb first
  typedef struct packed {
    logic [7:0]  cmd;
    logic [15:0] addr;
    logic [15:0] data;
  } spi_reg_frame_t;

  // same 40 bits seen as a shift word or as register fields
  typedef union packed {
    logic [FRAME_BITS-1:0] raw;
    spi_reg_frame_t        fields;
  } spi_frame_u;

  typedef struct packed {
    spi_op_e                op;
    logic [CS_SEL_BITS-1:0] cs_sel;
    logic [15:0]            addr;
    logic [15:0]            wdata;
  } spi_req_t;

  // one command buffer entry
  typedef struct packed {
    logic [CS_SEL_BITS-1:0] cs_sel;
    spi_frame_u             frame;
  } spi_cmd_t;

  typedef struct packed {
    logic [CS_SEL_BITS-1:0] cs_sel;
    spi_frame_u             rx;
  } spi_rsp_t;

endpackage

//--- verilog/spi_request_builder.sv
// Request builder packing host register requests into SPI frames under credit flow control
`timescale 1ns/1ps

module spi_request_builder #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk_in,
  input  logic              reset_n_in,
  input  logic              req_valid,
  input  spi_pkg::spi_req_t req,
  output logic              req_ready,
  input  logic              credit_return,
  output logic              push,
  output spi_pkg::spi_cmd_t cmd
);
  import spi_pkg::*;

  localparam int CRED_BITS = $clog2(FIFO_DEPTH + 1);

  logic [CRED_BITS-1:0] credits;
  logic                 accept;
  spi_frame_u           frame_next;

  // one free buffer slot per credit
  assign req_ready = (credits != '0);
  assign accept    = req_valid && req_ready;

  // build the frame through the field view
  always_comb begin
    frame_next.fields.cmd               = '0;
    frame_next.fields.cmd[CMD_READ_BIT] = (req.op == OP_READ);
    frame_next.fields.addr              = req.addr;
    // reads carry an empty data slot
    frame_next.fields.data              = (req.op == OP_READ) ? '0 : req.wdata;
  end

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      credits <= CRED_BITS'(FIFO_DEPTH);
    end else begin
      case ({accept, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      push <= 1'b0;
    end else begin
      push <= accept;
    end
  end

  // entry payload, valid only with push
  always_ff @(posedge clk_in) begin
    if (accept) begin
      cmd.cs_sel <= req.cs_sel;
      cmd.frame  <= frame_next;
    end
  end

endmodule

//--- verilog/spi_cmd_fifo.sv
// Command buffer holding SPI frames and returning one credit per entry popped
`timescale 1ns/1ps

module spi_cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk_in,
  input  logic              reset_n_in,
  input  logic              push,
  input  spi_pkg::spi_cmd_t cmd,
  input  logic              pop,
  output logic              head_valid,
  output spi_pkg::spi_cmd_t head,
  output logic              credit_return
);
  import spi_pkg::*;

  localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(FIFO_DEPTH - 1);

  spi_cmd_t            mem [FIFO_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
  endfunction

  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      // overflow is ruled out by the credits upstream
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_return <= pop;
    end
  end

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[wr_ptr] <= cmd;
    end
  end

endmodule

//--- verilog/spi_sclk_gen.sv
// Serial clock divider producing mode 3 sclk levels with fall and rise strobes
`timescale 1ns/1ps

module spi_sclk_gen #(
  parameter int DIV_WIDTH = 4
) (
  input  logic                 clk_in,
  input  logic                 reset_n_in,
  input  logic                 run,
  input  logic [DIV_WIDTH-1:0] div_max,
  output logic                 sclk,
  output logic                 fall_stb,
  output logic                 rise_stb
);

  logic [DIV_WIDTH-1:0] cnt;
  logic                 tc;

  // strobes lead the sclk edge they announce by one cycle
  assign tc       = run && (cnt == div_max);
  assign fall_stb = tc && sclk;
  assign rise_stb = tc && !sclk;

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      cnt  <= '0;
      sclk <= 1'b1;
    end else if (!run) begin
      // idle high, counter aligned for the next frame
      cnt  <= '0;
      sclk <= 1'b1;
    end else if (tc) begin
      cnt  <= '0;
      sclk <= ~sclk;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- verilog/spi_mode3_engine.sv
// Mode 3 shift engine sequencing chip select, sclk and 40-bit shift in and out per frame
`timescale 1ns/1ps

module spi_mode3_engine #(
  parameter int DIV_WIDTH = 4
) (
  input  logic                          clk_in,
  input  logic                          reset_n_in,
  input  logic                          head_valid,
  input  spi_pkg::spi_cmd_t             head,
  output logic                          pop,
  input  logic [DIV_WIDTH-1:0]          div_max,
  output logic                          sclk,
  output logic                          mosi,
  input  logic                          miso,
  output logic [spi_pkg::CS_LINES-1:0]  cs_n,
  output logic                          rsp_valid,
  output spi_pkg::spi_rsp_t             rsp
);
  import spi_pkg::*;

  localparam int BIT_CNT_BITS = $clog2(FRAME_BITS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SELECT,
    ST_SHIFT,
    ST_DESELECT
  } state_e;

  state_e                  state;
  logic                    run;
  logic                    fall_stb;
  logic                    rise_stb;
  logic [BIT_CNT_BITS-1:0] bit_cnt;
  logic                    last_bit;
  logic [DIV_WIDTH-1:0]    hold_cnt;
  logic                    hold_done;
  logic [CS_SEL_BITS-1:0]  cs_sel_q;
  logic [CS_LINES-1:0]     cs_dec;
  spi_frame_u              tx_q;
  spi_frame_u              rx_q;

  // sclk only toggles between the select and the last rise
  assign run       = (state == ST_SELECT) || (state == ST_SHIFT);
  assign last_bit  = (bit_cnt == BIT_CNT_BITS'(FRAME_BITS - 1));
  // half period of sclk-high tail, also reused as the idle gap
  assign hold_done = (hold_cnt >= div_max);
  assign pop       = (state == ST_IDLE) && head_valid && hold_done;

  assign mosi       = tx_q.raw[FRAME_BITS-1];
  assign rsp.cs_sel = cs_sel_q;
  assign rsp.rx     = rx_q;

  spi_sclk_gen #(
    .DIV_WIDTH (DIV_WIDTH)
  ) sclk_gen_i (
    .clk_in     (clk_in),
    .reset_n_in (reset_n_in),
    .run        (run),
    .div_max    (div_max),
    .sclk       (sclk),
    .fall_stb   (fall_stb),
    .rise_stb   (rise_stb)
  );

  // one-cold select for the head entry
  always_comb begin
    cs_dec                = '1;
    cs_dec[head.cs_sel]   = 1'b0;
  end

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state     <= ST_IDLE;
      bit_cnt   <= '0;
      hold_cnt  <= '0;
      cs_n      <= '1;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (!hold_done) begin
            hold_cnt <= hold_cnt + 1'b1;
          end
          if (pop) begin
            state   <= ST_SELECT;
            cs_n    <= cs_dec;
            bit_cnt <= '0;
          end
        end
        ST_SELECT: begin
          // first fall only opens the bit, bit 39 is already out
          if (fall_stb) begin
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          if (rise_stb) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
              state    <= ST_DESELECT;
              hold_cnt <= '0;
            end
          end
        end
        ST_DESELECT: begin
          if (hold_done) begin
            state     <= ST_IDLE;
            cs_n      <= '1;
            rsp_valid <= 1'b1;
            hold_cnt  <= '0;
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // transmit shifter, keeps mosi low out of reset
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      tx_q.raw <= '0;
    end else if (pop) begin
      tx_q.raw <= head.frame.raw;
    end else if ((state == ST_SHIFT) && fall_stb) begin
      tx_q.raw <= {tx_q.raw[FRAME_BITS-2:0], 1'b0};
    end
  end

  // receive side, sampled on each rise
  always_ff @(posedge clk_in) begin
    if (pop) begin
      cs_sel_q <= head.cs_sel;
    end
    if ((state == ST_SHIFT) && rise_stb) begin
      rx_q.raw <= {rx_q.raw[FRAME_BITS-2:0], miso};
    end
  end

endmodule

//--- verilog/spi_master_top.sv
// SPI register master top linking request builder, command buffer and mode 3 engine
`timescale 1ns/1ps

module spi_master_top #(
  parameter int FIFO_DEPTH = 4,
  parameter int DIV_WIDTH  = 4
) (
  input  logic                         clk_in,
  input  logic                         reset_n_in,
  input  logic                         req_valid,
  input  spi_pkg::spi_req_t            req,
  output logic                         req_ready,
  input  logic [DIV_WIDTH-1:0]         div_max,
  output logic                         sclk,
  output logic                         mosi,
  input  logic                         miso,
  output logic [spi_pkg::CS_LINES-1:0] cs_n,
  output logic                         rsp_valid,
  output spi_pkg::spi_rsp_t            rsp
);
  import spi_pkg::*;

  logic     push;
  logic     pop;
  logic     credit_return;
  logic     head_valid;
  spi_cmd_t cmd;
  spi_cmd_t head;

  spi_request_builder #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) builder_i (
    .clk_in        (clk_in),
    .reset_n_in    (reset_n_in),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .credit_return (credit_return),
    .push          (push),
    .cmd           (cmd)
  );

  spi_cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) cmd_fifo_i (
    .clk_in        (clk_in),
    .reset_n_in    (reset_n_in),
    .push          (push),
    .cmd           (cmd),
    .pop           (pop),
    .head_valid    (head_valid),
    .head          (head),
    .credit_return (credit_return)
  );

  spi_mode3_engine #(
    .DIV_WIDTH (DIV_WIDTH)
  ) engine_i (
    .clk_in     (clk_in),
    .reset_n_in (reset_n_in),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop),
    .div_max    (div_max),
    .sclk       (sclk),
    .mosi       (mosi),
    .miso       (miso),
    .cs_n       (cs_n),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

endmodule

//--- verif/spi_master_checker.sv
// Protocol checker bound onto the SPI master top-level pins
`timescale 1ns/1ps

module spi_master_checker (
  input logic                         clk_in,
  input logic                         reset_n_in,
  input logic                         sclk,
  input logic                         mosi,
  input logic [spi_pkg::CS_LINES-1:0] cs_n,
  input logic                         rsp_valid
);

  logic all_high;
  int   fail_count = 0;

  assign all_high = &cs_n;

  one_select_a: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    $countones(~cs_n) <= 1)
    else begin
      $error("more than one chip select low");
      fail_count++;
    end

  // sclk parks high between frames
  idle_sclk_a: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    all_high |-> sclk)
    else begin
      $error("sclk low with no chip select active");
      fail_count++;
    end

  // mosi only moves on a falling sclk or when a frame opens
  mosi_stable_a: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    (sclk && !$fell(all_high)) |-> $stable(mosi))
    else begin
      $error("mosi changed while sclk was high");
      fail_count++;
    end

  rsp_pulse_a: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    rsp_valid |=> !rsp_valid)
    else begin
      $error("rsp_valid high for two cycles in a row");
      fail_count++;
    end

endmodule

bind spi_master_top spi_master_checker checker_i (
  .clk_in     (clk_in),
  .reset_n_in (reset_n_in),
  .sclk       (sclk),
  .mosi       (mosi),
  .cs_n       (cs_n),
  .rsp_valid  (rsp_valid)
);

//--- verif/spi_master_tb.sv
// Testbench for the SPI register master with four peripheral models and a reference model
`timescale 1ns/1ps

module spi_master_tb;
  import spi_pkg::*;

  localparam int FIFO_DEPTH  = 4;
  localparam int DIV_WIDTH   = 4;
  localparam int CLK_PERIOD  = 40;
  localparam int NUM_ROUNDS  = 6;
  localparam int ROUND_REQS  = 12;
  localparam int NUM_REQS    = NUM_ROUNDS * ROUND_REQS;
  // pop to rsp_valid plus the idle gap, at the largest divider
  localparam int WORST_FRAME = 2 + 82 * (1 << DIV_WIDTH);
  localparam int TIMEOUT_NS  = NUM_REQS * WORST_FRAME * 2 * CLK_PERIOD + 200 * CLK_PERIOD;

  typedef struct packed {
    logic [CS_SEL_BITS-1:0] cs_sel;
    spi_frame_u             tx;
    spi_frame_u             rx;
  } exp_entry_t;

  logic                 clk_in;
  logic                 reset_n_in;
  logic                 req_valid;
  spi_req_t             req;
  logic                 req_ready;
  logic [DIV_WIDTH-1:0] div_max;
  logic                 sclk;
  logic                 mosi;
  logic                 miso;
  logic [CS_LINES-1:0]  cs_n;
  logic                 rsp_valid;
  spi_rsp_t             rsp;
  logic [CS_LINES-1:0]  miso_bits;

  integer      seed = 24;
  int          errors;
  int          protocol_errors;
  int          accepted;
  int          responses;
  bit          saw_backpressure;
  exp_entry_t  exp_q [$];
  logic [15:0] mirror [int];
  logic [15:0] periph_regs [int];
  logic        sclk_prev;
  int          phase_len;
  bit          phase_valid;

  spi_master_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .DIV_WIDTH  (DIV_WIDTH)
  ) spi_master_top_i (.*);

  // only the selected peripheral reaches miso
  assign miso = |(miso_bits & ~cs_n);

  function automatic int reg_key(input logic [CS_SEL_BITS-1:0] line, input logic [15:0] addr);
    return {14'd0, line, addr};
  endfunction

  // peripheral reply is the status byte, an empty address slot, then read data
  function automatic logic reply_bit(input int bit_idx, input logic [15:0] data);
    if (bit_idx < 8) begin
      return STATUS_BYTE[7 - bit_idx];
    end
    if (bit_idx < 24) begin
      return 1'b0;
    end
    return data[39 - bit_idx];
  endfunction

  task automatic report_mismatch(input string name, input logic [39:0] expected,
                                 input logic [39:0] actual);
    $display("error: %s expected %h got %h", name, expected, actual);
    errors++;
  endtask

  task automatic check_frame(input int line, input int bits, input logic [39:0] captured);
    exp_entry_t e;
    assert (exp_q.size() != 0) else begin
      $display("chip select %0d was driven low with no frame outstanding", line);
      errors++;
    end
    if (exp_q.size() != 0) begin
      e = exp_q[0];
      assert (line == int'(e.cs_sel)) else report_mismatch("cs_n line", 40'(e.cs_sel), 40'(line));
      assert (bits == FRAME_BITS) else report_mismatch("sclk rises", 40'(FRAME_BITS), 40'(bits));
      assert (captured == e.tx.raw) else report_mismatch("mosi frame", e.tx.raw, captured);
    end
  endtask

  // reference model runs at issue time, responses come back in order
  task automatic send_req(input spi_req_t r);
    exp_entry_t e;
    int         key;
    key              = reg_key(r.cs_sel, r.addr);
    e.cs_sel         = r.cs_sel;
    e.tx.fields.cmd  = {r.op == OP_READ, 7'h00};
    e.tx.fields.addr = r.addr;
    e.tx.fields.data = (r.op == OP_READ) ? 16'h0000 : r.wdata;
    e.rx.fields.cmd  = STATUS_BYTE;
    e.rx.fields.addr = 16'h0000;
    e.rx.fields.data = 16'h0000;
    if (r.op == OP_READ) begin
      e.rx.fields.data = mirror.exists(key) ? mirror[key] : 16'h0000;
    end else begin
      mirror[key] = r.wdata;
    end
    exp_q.push_back(e);
    req       = r;
    req_valid = 1'b1;
    while (!req_ready) begin
      @(posedge clk_in);
      #2;
    end
    @(posedge clk_in);
    #2;
  endtask

  for (genvar g = 0; g < CS_LINES; g++) begin : periph
    logic        line_miso;
    logic [39:0] shift_in;
    logic [15:0] rd_word;
    int          rises;

    assign miso_bits[g] = line_miso;

    initial begin
      line_miso = 1'b0;
    end

    always @(negedge cs_n[g]) begin
      if (reset_n_in) begin
        rises    = 0;
        shift_in = '0;
        rd_word  = '0;
        #2;
        line_miso = reply_bit(0, rd_word);
      end
    end

    always @(negedge sclk) begin
      if (reset_n_in && !cs_n[g]) begin
        #2;
        // command and address are in by now
        if (rises == 24) begin
          rd_word = 16'h0000;
          if (shift_in[23] && periph_regs.exists(reg_key(CS_SEL_BITS'(g), shift_in[15:0]))) begin
            rd_word = periph_regs[reg_key(CS_SEL_BITS'(g), shift_in[15:0])];
          end
        end
        line_miso = reply_bit(rises, rd_word);
      end
    end

    always @(posedge sclk) begin
      if (reset_n_in && !cs_n[g]) begin
        shift_in = {shift_in[38:0], mosi};
        rises++;
      end
    end

    always @(posedge cs_n[g]) begin
      if (reset_n_in) begin
        check_frame(g, rises, shift_in);
        if (rises == FRAME_BITS && !shift_in[39]) begin
          periph_regs[reg_key(CS_SEL_BITS'(g), shift_in[31:16])] = shift_in[15:0];
        end
      end
    end
  end

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired with %0d responses still missing", exp_q.size());
    $display("*** TEST FAILED ***");
    $finish;
  end

  // handshake, credit bounds and responses
  always @(posedge clk_in) begin
    exp_entry_t e;
    if (reset_n_in) begin
      assert (req_ready || (accepted - responses >= FIFO_DEPTH)) else begin
        $display("req_ready low with only %0d requests outstanding", accepted - responses);
        errors++;
      end
      assert (accepted - responses <= FIFO_DEPTH + 1) else begin
        $display("%0d requests outstanding, more than the buffer and engine hold",
                 accepted - responses);
        errors++;
      end
      if (!req_ready) begin
        saw_backpressure = 1'b1;
      end
      if (req_valid && req_ready) begin
        accepted++;
      end
      if (rsp_valid) begin
        responses++;
        assert (exp_q.size() != 0) else begin
          $display("response arrived with no request outstanding");
          errors++;
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          assert (rsp.cs_sel == e.cs_sel) else
            report_mismatch("rsp.cs_sel", 40'(e.cs_sel), 40'(rsp.cs_sel));
          assert (rsp.rx.fields.cmd == STATUS_BYTE) else
            report_mismatch("rsp.rx.cmd", 40'(STATUS_BYTE), 40'(rsp.rx.fields.cmd));
          assert (rsp.rx.raw == e.rx.raw) else report_mismatch("rsp.rx", e.rx.raw, rsp.rx.raw);
        end
      end
    end
  end

  // sclk half periods bounded by two sclk edges inside a frame
  always @(posedge clk_in) begin
    if (!reset_n_in || (&cs_n)) begin
      phase_valid = 1'b0;
      phase_len   = 0;
    end else if (sclk != sclk_prev) begin
      if (phase_valid) begin
        assert (phase_len == int'(div_max) + 1) else
          report_mismatch("sclk half period", 40'(int'(div_max) + 1), 40'(phase_len));
      end
      phase_valid = 1'b1;
      phase_len   = 1;
    end else begin
      phase_len++;
    end
    sclk_prev = sclk;
  end

  initial begin
    spi_req_t    r;
    logic [31:0] rnd;
    errors           = 0;
    protocol_errors  = 0;
    accepted         = 0;
    responses        = 0;
    saw_backpressure = 1'b0;
    reset_n_in       = 1'b0;
    req_valid        = 1'b0;
    req              = '0;
    div_max          = '0;
    repeat (5) @(posedge clk_in);
    #2;
    reset_n_in = 1'b1;
    @(posedge clk_in);
    #2;
    assert (req_ready === 1'b1) else report_mismatch("req_ready", 40'h1, 40'(req_ready));
    assert (rsp_valid === 1'b0) else report_mismatch("rsp_valid", 40'h0, 40'(rsp_valid));
    assert (sclk === 1'b1) else report_mismatch("sclk", 40'h1, 40'(sclk));
    assert (cs_n === '1) else report_mismatch("cs_n", 40'hF, 40'(cs_n));
    assert (mosi === 1'b0) else report_mismatch("mosi", 40'h0, 40'(mosi));

    for (int round = 0; round < NUM_ROUNDS; round++) begin
      rnd     = $random(seed);
      div_max = rnd[DIV_WIDTH-1:0];
      // back-to-back burst, writes first and then reads
      for (int n = 0; n < ROUND_REQS; n++) begin
        rnd      = $random(seed);
        r.op     = (n < ROUND_REQS / 2) ? OP_WRITE : OP_READ;
        r.cs_sel = rnd[1:0];
        r.wdata  = rnd[31:16];
        // small pool so reads hit earlier writes, 0x80xx is never written
        r.addr   = {13'h0240, rnd[4:2]};
        if (r.op == OP_READ && rnd[7]) begin
          r.addr = {8'h80, rnd[15:8]};
        end
        send_req(r);
      end
      req_valid = 1'b0;
      while (exp_q.size() != 0) begin
        @(posedge clk_in);
        #2;
      end
    end

    assert (saw_backpressure) else begin
      $display("req_ready never went low during back-to-back requests");
      errors++;
    end
    assert (accepted == NUM_REQS && responses == NUM_REQS) else begin
      $display("%0d requests accepted and %0d responses for %0d issued",
               accepted, responses, NUM_REQS);
      errors++;
    end
    protocol_errors = spi_master_top_i.checker_i.fail_count;
    $display("responses: %0d of %0d, errors: %0d, protocol errors: %0d",
             responses, NUM_REQS, errors, protocol_errors);
    if (errors == 0 && protocol_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- project.f
verilog/spi_pkg.sv
verilog/spi_request_builder.sv
verilog/spi_cmd_fifo.sv
verilog/spi_sclk_gen.sv
verilog/spi_mode3_engine.sv
verilog/spi_master_top.sv
verif/spi_master_checker.sv
verif/spi_master_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI master simulation with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module spi_master_tb -f project.f --Mdir "$BUILD_DIR" -o spi_master_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/spi_master_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
